//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

   // datapath and field widths
   localparam int data_w = 32;
   localparam int reg_w = 3;
   localparam int imm_w = 16;
   localparam int op_w = 4;

   // bits left below the opcode and the immediate-form flag
   localparam int payload_w = data_w - op_w - 1;

   // opcodes, codes 8 to 15 are no-ops
   localparam logic [op_w-1:0] op_mov = 4'd0;
   localparam logic [op_w-1:0] op_add = 4'd1;
   localparam logic [op_w-1:0] op_sub = 4'd2;
   localparam logic [op_w-1:0] op_and = 4'd3;
   localparam logic [op_w-1:0] op_or = 4'd4;
   localparam logic [op_w-1:0] op_xor = 4'd5;
   localparam logic [op_w-1:0] op_xchg = 4'd6;
   localparam logic [op_w-1:0] op_store = 4'd7;

   // register form
   typedef struct packed {
      logic [reg_w-1:0]               reg_a;
      logic [reg_w-1:0]               reg_b;
      logic [payload_w-2*reg_w-1:0]   unused;
   } rr_fields_s;

   // immediate form, imm is zero-extended into operand b
   typedef struct packed {
      logic [reg_w-1:0]               reg_a;
      logic [payload_w-reg_w-imm_w-1:0] unused;
      logic [imm_w-1:0]               imm;
   } ri_fields_s;

   typedef union packed {
      rr_fields_s rr;
      ri_fields_s ri;
   } instr_payload_u;

endpackage

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic [core_pkg::reg_w-1:0]  rd_addr_a,
   input  logic [core_pkg::reg_w-1:0]  rd_addr_b,
   output logic [core_pkg::data_w-1:0] rd_data_a,
   output logic [core_pkg::data_w-1:0] rd_data_b,
   input  logic                        wr_en_a,
   input  logic [core_pkg::reg_w-1:0]  wr_addr_a,
   input  logic [core_pkg::data_w-1:0] wr_data_a,
   input  logic                        wr_en_b,
   input  logic [core_pkg::reg_w-1:0]  wr_addr_b,
   input  logic [core_pkg::data_w-1:0] wr_data_b
);

   import core_pkg::*;

   logic [data_w-1:0] regs [2**reg_w];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 2**reg_w; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wr_en_a) begin
            regs[wr_addr_a] <= wr_data_a;
         end
         // port b comes last, so it wins when both hit one register
         if (wr_en_b) begin
            regs[wr_addr_b] <= wr_data_b;
         end
      end
   end

   // combinational reads for decode
   assign rd_data_a = regs[rd_addr_a];
   assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        instr_valid,
   output logic                        instr_ready,
   input  logic [core_pkg::data_w-1:0] instr_word,
   output logic [core_pkg::reg_w-1:0]  rf_addr_a,
   output logic [core_pkg::reg_w-1:0]  rf_addr_b,
   input  logic [core_pkg::data_w-1:0] rf_data_a,
   input  logic [core_pkg::data_w-1:0] rf_data_b,
   output logic                        d_valid,
   input  logic                        d_ready,
   output logic [core_pkg::op_w-1:0]   d_op,
   output logic [core_pkg::reg_w-1:0]  d_reg_a,
   output logic [core_pkg::reg_w-1:0]  d_reg_b,
   output logic [core_pkg::data_w-1:0] d_val_a,
   output logic [core_pkg::data_w-1:0] d_val_b,
   output logic                        d_wr_a,
   output logic                        d_wr_b,
   input  logic                        e_valid,
   input  logic [core_pkg::reg_w-1:0]  e_reg_a,
   input  logic [core_pkg::reg_w-1:0]  e_reg_b,
   input  logic                        e_wr_a,
   input  logic                        e_wr_b,
   input  logic                        res_valid,
   input  logic [core_pkg::reg_w-1:0]  res_reg_a,
   input  logic [core_pkg::reg_w-1:0]  res_reg_b,
   input  logic                        res_wr_a,
   input  logic                        res_wr_b,
   output logic                        busy
);

   import core_pkg::*;

   logic              hold_valid;
   logic [data_w-1:0] hold_word;
   logic [op_w-1:0]   op;
   logic              imm_flag;
   logic              use_imm;
   instr_payload_u    payload;
   logic              known_op;
   logic              reads_a;
   logic              reads_b;
   logic              hazard;

   // true if a downstream item will still write register src
   function automatic logic pending_write(
      input logic             vld,
      input logic             wr_a,
      input logic [reg_w-1:0] reg_a,
      input logic             wr_b,
      input logic [reg_w-1:0] reg_b,
      input logic [reg_w-1:0] src
   );
      return vld && ((wr_a && reg_a == src) || (wr_b && reg_b == src));
   endfunction

   // word fields
   assign op = hold_word[data_w-1 -: op_w];
   assign imm_flag = hold_word[payload_w];
   assign payload = hold_word[payload_w-1:0];
   // exchange ignores the flag and always uses the register form
   assign use_imm = imm_flag && (op != op_xchg);

   // register a sits at the same place in both forms
   assign rf_addr_a = payload.rr.reg_a;
   assign rf_addr_b = payload.rr.reg_b;

   always_comb begin
      known_op = 1'b1;
      reads_a = 1'b0;
      d_wr_a = 1'b0;
      d_wr_b = 1'b0;
      case (op)
         op_mov: d_wr_a = 1'b1;
         op_add, op_sub, op_and, op_or, op_xor: begin
            reads_a = 1'b1;
            d_wr_a = 1'b1;
         end
         op_xchg: begin
            reads_a = 1'b1;
            d_wr_a = 1'b1;
            d_wr_b = 1'b1;
         end
         op_store: reads_a = 1'b1;
         default: known_op = 1'b0;
      endcase
   end

   assign reads_b = known_op && !use_imm;

   // interlock against execute and the held result item
   assign hazard =
      (reads_a && (pending_write(e_valid, e_wr_a, e_reg_a, e_wr_b, e_reg_b, rf_addr_a) ||
                   pending_write(res_valid, res_wr_a, res_reg_a, res_wr_b, res_reg_b,
                                 rf_addr_a))) ||
      (reads_b && (pending_write(e_valid, e_wr_a, e_reg_a, e_wr_b, e_reg_b, rf_addr_b) ||
                   pending_write(res_valid, res_wr_a, res_reg_a, res_wr_b, res_reg_b,
                                 rf_addr_b)));

   assign d_valid = hold_valid && !hazard;
   assign d_op = op;
   assign d_reg_a = rf_addr_a;
   assign d_reg_b = rf_addr_b;
   assign d_val_a = rf_data_a;
   assign d_val_b = use_imm ? {{(data_w-imm_w){1'b0}}, payload.ri.imm} : rf_data_b;

   // empty or emptying this cycle
   assign instr_ready = !hold_valid || (d_valid && d_ready);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hold_valid <= 1'b0;
      end else if (instr_ready) begin
         hold_valid <= instr_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (instr_valid && instr_ready) begin
         hold_word <= instr_word;
      end
   end

   assign busy = hold_valid || e_valid || res_valid;

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          d_valid,
   output logic                          d_ready,
   input  logic [core_pkg::op_w-1:0]     d_op,
   input  logic [core_pkg::reg_w-1:0]    d_reg_a,
   input  logic [core_pkg::reg_w-1:0]    d_reg_b,
   input  logic [core_pkg::data_w-1:0]   d_val_a,
   input  logic [core_pkg::data_w-1:0]   d_val_b,
   input  logic                          d_wr_a,
   input  logic                          d_wr_b,
   output logic                          e_valid,
   input  logic                          e_ready,
   output logic [2*core_pkg::data_w-1:0] e_result,
   output logic [core_pkg::reg_w-1:0]    e_reg_a,
   output logic [core_pkg::reg_w-1:0]    e_reg_b,
   output logic                          e_wr_a,
   output logic                          e_wr_b,
   output logic                          e_store
);

   import core_pkg::*;

   logic [2*data_w-1:0] alu_result;
   logic                accept;

   assign d_ready = !e_valid || e_ready;
   assign accept = d_valid && d_ready;

   // low half goes to reg a, high half to reg b or the store address
   always_comb begin
      case (d_op)
         op_mov:   alu_result = {{data_w{1'b0}}, d_val_b};
         op_add:   alu_result = {{data_w{1'b0}}, d_val_a + d_val_b};
         op_sub:   alu_result = {{data_w{1'b0}}, d_val_a - d_val_b};
         op_and:   alu_result = {{data_w{1'b0}}, d_val_a & d_val_b};
         op_or:    alu_result = {{data_w{1'b0}}, d_val_a | d_val_b};
         op_xor:   alu_result = {{data_w{1'b0}}, d_val_a ^ d_val_b};
         op_xchg:  alu_result = {d_val_a, d_val_b};
         op_store: alu_result = {d_val_b, d_val_a};
         default:  alu_result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         e_valid <= 1'b0;
      end else if (d_ready) begin
         e_valid <= d_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         e_result <= alu_result;
         e_reg_a <= d_reg_a;
         e_reg_b <= d_reg_b;
         e_wr_a <= d_wr_a;
         e_wr_b <= d_wr_b;
         e_store <= (d_op == op_store);
      end
   end

endmodule

`default_nettype wire

//--- verilog/result_stage.sv
`timescale 1ns/1ns
`default_nettype none

module result_stage #(
   parameter int wmem_addr_w = 16
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          e_valid,
   output logic                          e_ready,
   input  logic [2*core_pkg::data_w-1:0] e_result,
   input  logic [core_pkg::reg_w-1:0]    e_reg_a,
   input  logic [core_pkg::reg_w-1:0]    e_reg_b,
   input  logic                          e_wr_a,
   input  logic                          e_wr_b,
   input  logic                          e_store,
   output logic                          rf_wr_en_a,
   output logic [core_pkg::reg_w-1:0]    rf_wr_addr_a,
   output logic [core_pkg::data_w-1:0]   rf_wr_data_a,
   output logic                          rf_wr_en_b,
   output logic [core_pkg::reg_w-1:0]    rf_wr_addr_b,
   output logic [core_pkg::data_w-1:0]   rf_wr_data_b,
   output logic                          res_valid,
   output logic [core_pkg::reg_w-1:0]    res_reg_a,
   output logic [core_pkg::reg_w-1:0]    res_reg_b,
   output logic                          res_wr_a,
   output logic                          res_wr_b,
   output logic                          wmem_valid,
   input  logic                          wmem_ready,
   output logic [wmem_addr_w-1:0]        wmem_address,
   output logic [core_pkg::data_w-1:0]   wmem_wr_data
);

   import core_pkg::*;

   logic                   accept;
   logic [data_w-1:0]      store_data;
   logic [wmem_addr_w-1:0] store_addr;

   // only a store waiting on the memory port occupies this stage
   assign e_ready = !res_valid || wmem_ready;
   assign accept = e_valid && e_ready;

   // register results are written at the accepting edge
   assign rf_wr_en_a = accept && e_wr_a;
   assign rf_wr_addr_a = e_reg_a;
   assign rf_wr_data_a = e_result[data_w-1:0];

   // second port, exchange only
   assign rf_wr_en_b = accept && e_wr_b;
   assign rf_wr_addr_b = e_reg_b;
   assign rf_wr_data_b = e_result[2*data_w-1:data_w];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         res_valid <= 1'b0;
      end else if (e_ready) begin
         res_valid <= e_valid && e_store;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && e_store) begin
         store_data <= e_result[data_w-1:0];
         store_addr <= e_result[data_w +: wmem_addr_w];
         res_reg_a <= e_reg_a;
         res_reg_b <= e_reg_b;
         res_wr_a <= e_wr_a;
         res_wr_b <= e_wr_b;
      end
   end

   // valid comes straight from the held flag, never from ready
   assign wmem_valid = res_valid;
   assign wmem_address = store_addr;
   assign wmem_wr_data = store_data;

endmodule

`default_nettype wire

//--- verilog/mini_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module mini_core_top #(
   parameter int wmem_addr_w = 16
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        instr_valid,
   output logic                        instr_ready,
   input  logic [core_pkg::data_w-1:0] instr_word,
   output logic                        wmem_valid,
   input  logic                        wmem_ready,
   output logic [wmem_addr_w-1:0]      wmem_address,
   output logic [core_pkg::data_w-1:0] wmem_wr_data,
   output logic                        busy
);

   import core_pkg::*;

   // register file read side
   logic [reg_w-1:0]    rf_addr_a;
   logic [reg_w-1:0]    rf_addr_b;
   logic [data_w-1:0]   rf_data_a;
   logic [data_w-1:0]   rf_data_b;

   // decode to execute
   logic                d_valid;
   logic                d_ready;
   logic [op_w-1:0]     d_op;
   logic [reg_w-1:0]    d_reg_a;
   logic [reg_w-1:0]    d_reg_b;
   logic [data_w-1:0]   d_val_a;
   logic [data_w-1:0]   d_val_b;
   logic                d_wr_a;
   logic                d_wr_b;

   // execute to result
   logic                e_valid;
   logic                e_ready;
   logic [2*data_w-1:0] e_result;
   logic [reg_w-1:0]    e_reg_a;
   logic [reg_w-1:0]    e_reg_b;
   logic                e_wr_a;
   logic                e_wr_b;
   logic                e_store;

   // writeback and held store destinations
   logic                rf_wr_en_a;
   logic [reg_w-1:0]    rf_wr_addr_a;
   logic [data_w-1:0]   rf_wr_data_a;
   logic                rf_wr_en_b;
   logic [reg_w-1:0]    rf_wr_addr_b;
   logic [data_w-1:0]   rf_wr_data_b;
   logic                res_valid;
   logic [reg_w-1:0]    res_reg_a;
   logic [reg_w-1:0]    res_reg_b;
   logic                res_wr_a;
   logic                res_wr_b;

   decode_stage u_decode (
      .clk(clk), .arst_n(arst_n),
      .instr_valid(instr_valid), .instr_ready(instr_ready), .instr_word(instr_word),
      .rf_addr_a(rf_addr_a), .rf_addr_b(rf_addr_b),
      .rf_data_a(rf_data_a), .rf_data_b(rf_data_b),
      .d_valid(d_valid), .d_ready(d_ready), .d_op(d_op),
      .d_reg_a(d_reg_a), .d_reg_b(d_reg_b), .d_val_a(d_val_a), .d_val_b(d_val_b),
      .d_wr_a(d_wr_a), .d_wr_b(d_wr_b),
      .e_valid(e_valid), .e_reg_a(e_reg_a), .e_reg_b(e_reg_b),
      .e_wr_a(e_wr_a), .e_wr_b(e_wr_b),
      .res_valid(res_valid), .res_reg_a(res_reg_a), .res_reg_b(res_reg_b),
      .res_wr_a(res_wr_a), .res_wr_b(res_wr_b),
      .busy(busy)
   );

   register_file u_regs (
      .clk(clk), .arst_n(arst_n),
      .rd_addr_a(rf_addr_a), .rd_addr_b(rf_addr_b),
      .rd_data_a(rf_data_a), .rd_data_b(rf_data_b),
      .wr_en_a(rf_wr_en_a), .wr_addr_a(rf_wr_addr_a), .wr_data_a(rf_wr_data_a),
      .wr_en_b(rf_wr_en_b), .wr_addr_b(rf_wr_addr_b), .wr_data_b(rf_wr_data_b)
   );

   execute_stage u_execute (
      .clk(clk), .arst_n(arst_n),
      .d_valid(d_valid), .d_ready(d_ready), .d_op(d_op),
      .d_reg_a(d_reg_a), .d_reg_b(d_reg_b), .d_val_a(d_val_a), .d_val_b(d_val_b),
      .d_wr_a(d_wr_a), .d_wr_b(d_wr_b),
      .e_valid(e_valid), .e_ready(e_ready), .e_result(e_result),
      .e_reg_a(e_reg_a), .e_reg_b(e_reg_b), .e_wr_a(e_wr_a), .e_wr_b(e_wr_b),
      .e_store(e_store)
   );

   result_stage #(.wmem_addr_w(wmem_addr_w)) u_result (
      .clk(clk), .arst_n(arst_n),
      .e_valid(e_valid), .e_ready(e_ready), .e_result(e_result),
      .e_reg_a(e_reg_a), .e_reg_b(e_reg_b), .e_wr_a(e_wr_a), .e_wr_b(e_wr_b),
      .e_store(e_store),
      .rf_wr_en_a(rf_wr_en_a), .rf_wr_addr_a(rf_wr_addr_a), .rf_wr_data_a(rf_wr_data_a),
      .rf_wr_en_b(rf_wr_en_b), .rf_wr_addr_b(rf_wr_addr_b), .rf_wr_data_b(rf_wr_data_b),
      .res_valid(res_valid), .res_reg_a(res_reg_a), .res_reg_b(res_reg_b),
      .res_wr_a(res_wr_a), .res_wr_b(res_wr_b),
      .wmem_valid(wmem_valid), .wmem_ready(wmem_ready),
      .wmem_address(wmem_address), .wmem_wr_data(wmem_wr_data)
   );

endmodule

`default_nettype wire

//--- test/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// sequential reference state, one instruction at a time in program order
logic [31:0] model_regs [8];
logic [15:0] exp_addr [$];
logic [31:0] exp_data [$];

function automatic logic [31:0] encode_rr(input logic [3:0] op, input int ra, input int rb);
   return {op, 1'b0, ra[2:0], rb[2:0], 21'h0};
endfunction

function automatic logic [31:0] encode_ri(input logic [3:0] op, input int ra,
                                          input logic [15:0] imm);
   return {op, 1'b1, ra[2:0], 8'h0, imm};
endfunction

// stores favoured so results get seen often; spare bits are random junk
function automatic logic [31:0] random_instr();
   logic [3:0] op;
   int         pick;
   pick = $urandom % 20;
   op = (pick >= 16) ? op_store : pick[3:0];
   return {op, 1'($urandom), 27'($urandom)};
endfunction

task automatic execute_model(input logic [31:0] word);
   logic [3:0]  op;
   logic [2:0]  ra;
   logic [2:0]  rb;
   logic [31:0] a;
   logic [31:0] b;
   op = word[31:28];
   ra = word[26:24];
   rb = word[23:21];
   a = model_regs[ra];
   // exchange always takes the register form
   b = (word[27] && op != op_xchg) ? {16'h0, word[15:0]} : model_regs[rb];
   case (op)
      op_mov: model_regs[ra] = b;
      op_add: model_regs[ra] = a + b;
      op_sub: model_regs[ra] = a - b;
      op_and: model_regs[ra] = a & b;
      op_or:  model_regs[ra] = a | b;
      op_xor: model_regs[ra] = a ^ b;
      op_xchg: begin
         model_regs[ra] = b;
         model_regs[rb] = a;
      end
      op_store: begin
         exp_addr.push_back(b[15:0]);
         exp_data.push_back(a);
      end
      default: ;
   endcase
endtask

`endif

//--- test/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;

   import core_pkg::*;

   logic        clk;
   logic        arst_n;
   logic        instr_valid;
   logic        instr_ready;
   logic [31:0] instr_word;
   logic        wmem_valid;
   logic        wmem_ready;
   logic [15:0] wmem_address;
   logic [31:0] wmem_wr_data;
   logic        busy;

   logic [31:0] program_q [$];
   logic        taken;
   logic        hold_seen;
   logic [15:0] hold_addr;
   logic [31:0] hold_data;

   `include "core_model.svh"

   mini_core_top DUT (
      .clk(clk), .arst_n(arst_n),
      .instr_valid(instr_valid), .instr_ready(instr_ready), .instr_word(instr_word),
      .wmem_valid(wmem_valid), .wmem_ready(wmem_ready),
      .wmem_address(wmem_address), .wmem_wr_data(wmem_wr_data),
      .busy(busy)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Test failed");
      $fatal(1, "wait expired");
   endtask

   // memory port as seen just before the rising edge
   task automatic watch_memory();
      if (wmem_valid) begin
         if (hold_seen) begin
            check_value("held address", hold_addr, wmem_address);
            check_value("held data", hold_data, wmem_wr_data);
         end
         if (!wmem_ready) begin
            hold_seen = 1'b1;
            hold_addr = wmem_address;
            hold_data = wmem_wr_data;
         end else if (exp_addr.size() == 0) begin
            $display("Store to %h arrived while the model expected no store", wmem_address);
            $display("Test failed");
            $fatal(1, "unexpected store");
         end else begin
            check_value("store address", exp_addr.pop_front(), wmem_address);
            check_value("store data", exp_data.pop_front(), wmem_wr_data);
            hold_seen = 1'b0;
         end
      end else if (hold_seen) begin
         $display("wmem_valid fell before its store was taken");
         $display("Test failed");
         $fatal(1, "store withdrawn");
      end
   endtask

   // drive at the falling edge, sample handshakes before the rising edge
   task automatic run_cycle();
      @(negedge clk);
      if (taken) begin
         instr_valid = 1'b0;
         instr_word = $urandom;
         taken = 1'b0;
      end
      if (!instr_valid && program_q.size() > 0 && ($urandom % 4) != 0) begin
         instr_valid = 1'b1;
         instr_word = program_q.pop_front();
      end
      wmem_ready = 1'($urandom % 2);
      #1;
      watch_memory();
      if (instr_valid && instr_ready) begin
         execute_model(instr_word);
         taken = 1'b1;
      end
   endtask

   task automatic build_program();
      // stores right after reset read zero
      program_q.push_back(encode_ri(op_store, 3, 16'h0100));
      program_q.push_back(encode_rr(op_store, 5, 6));
      program_q.push_back(encode_ri(op_mov, 1, 16'h1234));
      program_q.push_back(encode_ri(op_mov, 2, 16'hff0f));
      // r3 gets high bits set
      program_q.push_back(encode_rr(op_sub, 3, 1));
      program_q.push_back(encode_rr(op_mov, 4, 3));
      for (int op = 1; op <= 5; op++) begin
         program_q.push_back(encode_rr(op[3:0], 4, 3));
         program_q.push_back(encode_ri(op[3:0], 4, 16'h5a5a));
         program_q.push_back(encode_rr(op_store, 4, 4));
      end
      program_q.push_back(encode_rr(op_xchg, 1, 2));
      program_q.push_back(encode_rr(op_xchg, 3, 3));
      program_q.push_back(encode_ri(op_store, 1, 16'h0011));
      program_q.push_back(encode_ri(op_store, 2, 16'h0012));
      program_q.push_back(encode_rr(op_store, 3, 2));
      // dependent chain on r6, then no-ops that must not touch it
      program_q.push_back(encode_ri(op_mov, 6, 16'h0003));
      for (int i = 0; i < 6; i++) begin
         program_q.push_back(encode_rr(op_add, 6, 6));
      end
      for (int op = 8; op < 16; op++) begin
         program_q.push_back(encode_rr(op[3:0], 6, 1));
      end
      program_q.push_back(encode_ri(op_store, 6, 16'h0066));
      for (int i = 0; i < 400; i++) begin
         program_q.push_back(random_instr());
      end
      // every register lands at the address of its own number
      for (int r = 0; r < 8; r++) begin
         program_q.push_back(encode_ri(op_store, r, r[15:0]));
      end
   endtask

   initial begin
      int stall;
      int drain;
      void'($urandom(32'h81f330a1));
      arst_n = 1'b0;
      instr_valid = 1'b0;
      instr_word = '0;
      wmem_ready = 1'b0;
      taken = 1'b0;
      hold_seen = 1'b0;
      for (int i = 0; i < 8; i++) begin
         model_regs[i] = '0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      #1;
      check_value("reset wmem_valid", 32'd0, wmem_valid);
      check_value("reset busy", 32'd0, busy);
      check_value("reset instr_ready", 32'd1, instr_ready);
      build_program();
      stall = 0;
      while (program_q.size() > 0 || instr_valid) begin
         run_cycle();
         stall = taken ? 0 : stall + 1;
         if (stall > 200) begin
            report_timeout("the instruction channel to accept a word");
         end
      end
      drain = 0;
      while (busy && drain < 500) begin
         run_cycle();
         drain++;
      end
      if (busy) begin
         report_timeout("busy to fall after the last instruction");
      end
      if (exp_addr.size() == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("%0d expected stores never reached the memory port", exp_addr.size());
         $display("Test failed");
         $fatal(1, "missing stores");
      end
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+test
verilog/core_pkg.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/mini_core_top.sv
test/core_tb.sv
